// ==== psx_bus_arbiter.sv ====
`default_nettype none

module psx_bus_arbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [1:0]                   bus_req,
    output logic [1:0]                   grant,
    input  psx_pad_pkg::xfer_req_t [1:0] port_req,
    output psx_pad_pkg::xfer_rsp_t [1:0] port_rsp,
    output psx_pad_pkg::xfer_req_t       eng_req,
    input  psx_pad_pkg::xfer_rsp_t       eng_rsp
);

    logic owner;   // current or last served port
    logic pick;

    // on a tie the port not served last wins
    assign pick = (bus_req == 2'b11) ? ~owner : bus_req[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= 2'b00;
            owner <= 1'b1;   // port 0 first on a tie
        end else if (grant == 2'b00) begin
            if (|bus_req) begin
                owner <= pick;
                grant <= pick ? 2'b10 : 2'b01;
            end
        end else if (!bus_req[owner]) begin
            grant <= 2'b00;
        end
    end

    // only the owner reaches the engine
    assign eng_req = (|grant) ? port_req[owner] : '0;

    assign port_rsp[0] = grant[0] ? eng_rsp : '0;
    assign port_rsp[1] = grant[1] ? eng_rsp : '0;

endmodule

`default_nettype wire

// ==== psx_byte_xfer.sv ====
`default_nettype none

module psx_byte_xfer #(
    parameter int HALF_BIT    = psx_pad_pkg::DEF_HALF_BIT,
    parameter int ACK_TIMEOUT = psx_pad_pkg::DEF_ACK_TIMEOUT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  psx_pad_pkg::xfer_req_t req,
    output psx_pad_pkg::xfer_rsp_t rsp,
    input  logic                   data,
    input  logic                   ack,
    output logic                   psx_clk,
    output logic                   cmd
);

    localparam int PW = $clog2(HALF_BIT + 1);
    localparam int AW = $clog2(ACK_TIMEOUT + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOW,
        S_HIGH,
        S_ACK
    } state_t;

    state_t        state;
    logic [PW-1:0] phase;
    logic [2:0]    bit_cnt;
    logic [AW-1:0] ack_cnt;
    logic [7:0]    tx_sr;   // bits still to send
    logic [7:0]    rx_sr;
    logic          last;
    logic          done;
    logic          no_ack;

    assign rsp = '{done: done, no_ack: no_ack, rx_byte: rx_sr};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            phase   <= '0;
            bit_cnt <= '0;
            ack_cnt <= '0;
            psx_clk <= 1'b1;
            cmd     <= 1'b1;
            done    <= 1'b0;
            no_ack  <= 1'b0;
        end else begin
            done   <= 1'b0;
            no_ack <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req.start) begin
                        psx_clk <= 1'b0;
                        cmd     <= req.tx_byte[0];    // lsb first
                        tx_sr   <= {1'b1, req.tx_byte[7:1]};
                        last    <= req.last;
                        phase   <= '0;
                        bit_cnt <= '0;
                        state   <= S_LOW;
                    end
                end
                S_LOW: begin
                    if (phase == PW'(HALF_BIT - 1)) begin
                        phase   <= '0;
                        psx_clk <= 1'b1;
                        rx_sr   <= {data, rx_sr[7:1]};  // sample at rising edge
                        state   <= S_HIGH;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                S_HIGH: begin
                    if (phase == PW'(HALF_BIT - 1)) begin
                        phase <= '0;
                        if (bit_cnt == 3'd7) begin
                            cmd <= 1'b1;
                            if (last) begin
                                done  <= 1'b1;
                                state <= S_IDLE;
                            end else begin
                                ack_cnt <= '0;
                                state   <= S_ACK;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            psx_clk <= 1'b0;
                            cmd     <= tx_sr[0];
                            tx_sr   <= {1'b1, tx_sr[7:1]};
                            state   <= S_LOW;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                S_ACK: begin
                    if (!ack) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else if (ack_cnt == AW'(ACK_TIMEOUT - 1)) begin
                        done   <= 1'b1;   // pad gone or not answering
                        no_ack <= 1'b1;
                        state  <= S_IDLE;
                    end else begin
                        ack_cnt <= ack_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== psx_dual_pad.f ====
psx_pad_pkg.sv
psx_byte_xfer.sv
psx_pad_poller.sv
psx_bus_arbiter.sv
psx_dual_pad.sv
psx_pad_model.sv
tb_psx_dual_pad.sv

// ==== psx_dual_pad.sv ====
`default_nettype none

module psx_dual_pad #(
    parameter int HALF_BIT    = psx_pad_pkg::DEF_HALF_BIT,
    parameter int ACK_TIMEOUT = psx_pad_pkg::DEF_ACK_TIMEOUT,
    parameter int BYTE_GAP    = psx_pad_pkg::DEF_BYTE_GAP,
    parameter int BOOT_CYCLES = psx_pad_pkg::DEF_BOOT_CYCLES
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           data,
    input  logic                           ack,
    output logic                           psx_clk,
    output logic                           cmd,
    output logic [1:0]                     att,
    output psx_pad_pkg::pad_report_u [1:0] report,
    output logic [1:0]                     report_valid,
    output logic [1:0]                     poll_error
);
    import psx_pad_pkg::*;

    logic [1:0]      bus_req;
    logic [1:0]      grant;
    xfer_req_t [1:0] port_req;
    xfer_rsp_t [1:0] port_rsp;
    xfer_req_t       eng_req;
    xfer_rsp_t       eng_rsp;

    for (genvar p = 0; p < 2; p++) begin : g_port
        psx_pad_poller #(
            .BYTE_GAP    (BYTE_GAP),
            .BOOT_CYCLES (BOOT_CYCLES)
        ) u_poller (
            .clk          (clk),
            .rst          (rst),
            .bus_req      (bus_req[p]),
            .grant        (grant[p]),
            .att          (att[p]),
            .xfer_req     (port_req[p]),
            .xfer_rsp     (port_rsp[p]),
            .report       (report[p]),
            .report_valid (report_valid[p]),
            .poll_error   (poll_error[p])
        );
    end

    psx_bus_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (bus_req),
        .grant    (grant),
        .port_req (port_req),
        .port_rsp (port_rsp),
        .eng_req  (eng_req),
        .eng_rsp  (eng_rsp)
    );

    // shared serial engine
    psx_byte_xfer #(
        .HALF_BIT    (HALF_BIT),
        .ACK_TIMEOUT (ACK_TIMEOUT)
    ) u_xfer (
        .clk     (clk),
        .rst     (rst),
        .req     (eng_req),
        .rsp     (eng_rsp),
        .data    (data),
        .ack     (ack),
        .psx_clk (psx_clk),
        .cmd     (cmd)
    );

endmodule

`default_nettype wire

// ==== psx_pad_model.sv ====
`default_nettype none

module psx_pad_model (
    input  logic            clk,
    input  logic            rst,
    input  logic            att,
    input  logic            psx_clk,
    input  logic            cmd,
    input  logic            analog,
    input  logic [15:0]     buttons,
    input  logic [7:0]      rx,
    input  logic [7:0]      ry,
    input  logic [7:0]      lx,
    input  logic [7:0]      ly,
    input  logic [3:0]      drop_ack,   // byte left without ack, 4'hf for none
    output logic            data,
    output logic            ack,
    output logic [8:0][7:0] cmd_log
);

    logic [8:0][7:0] reply;
    logic [3:0]      last_idx;
    logic [3:0]      drop_q;
    logic [3:0]      byte_idx;
    logic [2:0]      bit_idx;
    logic [7:0]      cmd_sr;
    logic [2:0]      ack_cnt;    // counts 1..5 after a byte
    logic            att_q;
    logic            psx_clk_q;

    // low for 2 cycles, 3 cycles after the byte ends
    assign ack = !(!att && (ack_cnt == 3'd4 || ack_cnt == 3'd5));

    always @(posedge clk) begin
        if (rst) begin
            data      <= 1'b1;
            att_q     <= 1'b1;
            psx_clk_q <= 1'b1;
            byte_idx  <= '0;
            bit_idx   <= '0;
            ack_cnt   <= '0;
            cmd_sr    <= '0;
            cmd_log   <= '0;
            reply     <= '1;
            last_idx  <= 4'd4;
            drop_q    <= 4'hf;
        end else begin
            att_q     <= att;
            psx_clk_q <= psx_clk;
            if (att) begin
                data     <= 1'b1;   // released
                byte_idx <= '0;
                bit_idx  <= '0;
                ack_cnt  <= '0;
            end else begin
                if (att_q) begin
                    // frame starts, settings are frozen for its length
                    reply    <= {ly, lx, ry, rx, buttons[15:8], buttons[7:0], 8'h5a,
                                 analog ? 8'h73 : 8'h41, 8'hff};
                    last_idx <= analog ? 4'd8 : 4'd4;
                    drop_q   <= drop_ack;
                end
                if (ack_cnt != 3'd0) ack_cnt <= (ack_cnt == 3'd5) ? 3'd0 : ack_cnt + 3'd1;
                if (!psx_clk && psx_clk_q && byte_idx <= 4'd8) begin
                    data <= reply[byte_idx][bit_idx];   // lsb first
                end
                if (psx_clk && !psx_clk_q) begin
                    cmd_sr  <= {cmd, cmd_sr[7:1]};
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) begin
                        if (byte_idx <= 4'd8) cmd_log[byte_idx] <= {cmd, cmd_sr[7:1]};
                        if (byte_idx != last_idx && byte_idx != drop_q) ack_cnt <= 3'd1;
                        byte_idx <= byte_idx + 4'd1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== psx_pad_pkg.sv ====
`default_nettype none

package psx_pad_pkg;

    // defaults for the top level parameters
    localparam int DEF_HALF_BIT    = 4;     // cycles per psx_clk phase
    localparam int DEF_ACK_TIMEOUT = 60;    // cycles to wait for ack
    localparam int DEF_BYTE_GAP    = 8;
    localparam int DEF_BOOT_CYCLES = 1000;  // pad power-up wait

    // host command bytes
    localparam logic [7:0] CMD_START = 8'h01;
    localparam logic [7:0] CMD_POLL  = 8'h42;
    localparam logic [7:0] CMD_IDLE  = 8'h00;

    // first answer byte, tells digital from analog
    localparam logic [7:0] ID_DIGITAL = 8'h41;
    localparam logic [7:0] ID_ANALOG  = 8'h73;

    localparam int POLL_BYTES = 9;  // full analog frame

    // named view of a report, msb first
    typedef struct packed {
        logic [7:0]  pad;
        logic [7:0]  pad_id;
        logic [7:0]  ly;
        logic [7:0]  lx;
        logic [7:0]  ry;
        logic [7:0]  rx;
        logic [15:0] buttons;   // active low
    } pad_fields_t;

    // bytes[0] is the buttons low byte, as it arrives on the wire
    typedef union packed {
        logic [7:0][7:0] bytes;
        pad_fields_t     fields;
    } pad_report_u;

    // released buttons, centered sticks, no id
    localparam logic [63:0] REPORT_INIT = 64'h0000_8080_8080_ffff;

    // one byte transfer request
    typedef struct packed {
        logic       last;       // no ack wait after this byte
        logic       start;
        logic [7:0] tx_byte;
    } xfer_req_t;

    // transfer completion
    typedef struct packed {
        logic       done;
        logic       no_ack;
        logic [7:0] rx_byte;
    } xfer_rsp_t;

endpackage

`default_nettype wire

// ==== psx_pad_poller.sv ====
`default_nettype none

module psx_pad_poller #(
    parameter int BYTE_GAP    = psx_pad_pkg::DEF_BYTE_GAP,
    parameter int BOOT_CYCLES = psx_pad_pkg::DEF_BOOT_CYCLES
) (
    input  logic                     clk,
    input  logic                     rst,
    output logic                     bus_req,
    input  logic                     grant,
    output logic                     att,
    output psx_pad_pkg::xfer_req_t   xfer_req,
    input  psx_pad_pkg::xfer_rsp_t   xfer_rsp,
    output psx_pad_pkg::pad_report_u report,
    output logic                     report_valid,
    output logic                     poll_error
);
    import psx_pad_pkg::*;

    localparam int CNT_MAX = (BOOT_CYCLES > BYTE_GAP) ? BOOT_CYCLES : BYTE_GAP;
    localparam int CW      = $clog2(CNT_MAX + 1);

    localparam logic [3:0] LAST_ANALOG  = 4'(POLL_BYTES - 1);
    localparam logic [3:0] LAST_DIGITAL = 4'd4;   // id, 0x5a, two button bytes

    typedef enum logic [2:0] {
        S_BOOT,
        S_REQ,
        S_LOWER_ATT,
        S_GAP,
        S_SEND,
        S_WAIT,
        S_FINISH,
        S_IDLE_GAP
    } state_t;

    state_t        state;
    logic [CW-1:0] cnt;
    logic [3:0]    idx;       // byte within the frame
    logic          analog;
    logic          start;
    logic [7:0]    tx_byte;
    logic          is_last;
    logic          id_bad;
    pad_report_u   shadow;
    pad_report_u   shadow_next;

    always_comb begin
        case (idx)
            4'd0:    tx_byte = CMD_START;
            4'd1:    tx_byte = CMD_POLL;
            default: tx_byte = CMD_IDLE;
        endcase
    end

    // analog is stale for idx 0 and 1, neither can be last
    assign is_last = (idx == (analog ? LAST_ANALOG : LAST_DIGITAL));
    assign id_bad  = (xfer_rsp.rx_byte != ID_DIGITAL) && (xfer_rsp.rx_byte != ID_ANALOG);

    assign xfer_req = '{last: is_last, start: start, tx_byte: tx_byte};

    // where the answer byte lands
    always_comb begin
        shadow_next = shadow;
        if (idx == 4'd1) begin
            shadow_next.fields.pad_id = xfer_rsp.rx_byte;
        end else if (idx >= 4'd3) begin
            shadow_next.bytes[3'(idx - 4'd3)] = xfer_rsp.rx_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_BOOT;
            cnt          <= '0;
            idx          <= '0;
            analog       <= 1'b0;
            start        <= 1'b0;
            bus_req      <= 1'b0;
            att          <= 1'b1;
            report       <= REPORT_INIT;
            report_valid <= 1'b0;
            poll_error   <= 1'b0;
        end else begin
            start        <= 1'b0;
            report_valid <= 1'b0;
            poll_error   <= 1'b0;
            case (state)
                S_BOOT: begin
                    if (cnt == CW'(BOOT_CYCLES - 1)) begin
                        cnt     <= '0;
                        bus_req <= 1'b1;
                        state   <= S_REQ;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_REQ: if (grant) state <= S_LOWER_ATT;
                S_LOWER_ATT: begin
                    att    <= 1'b0;
                    cnt    <= '0;
                    idx    <= '0;
                    shadow <= REPORT_INIT;   // digital pads leave sticks centered
                    state  <= S_GAP;
                end
                S_GAP: begin
                    if (cnt == CW'(BYTE_GAP - 1)) state <= S_SEND;
                    else cnt <= cnt + 1'b1;
                end
                S_SEND: begin
                    start <= 1'b1;
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (xfer_rsp.done) begin
                        if (xfer_rsp.no_ack || (idx == 4'd1 && id_bad)) begin
                            poll_error <= 1'b1;   // keep last good report
                            att        <= 1'b1;
                            state      <= S_FINISH;
                        end else begin
                            shadow <= shadow_next;
                            if (idx == 4'd1) analog <= (xfer_rsp.rx_byte == ID_ANALOG);
                            if (is_last) begin
                                report       <= shadow_next;
                                report_valid <= 1'b1;
                                att          <= 1'b1;
                                state        <= S_FINISH;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= S_SEND;
                            end
                        end
                    end
                end
                S_FINISH: begin
                    bus_req <= 1'b0;   // releases grant
                    cnt     <= '0;
                    state   <= S_IDLE_GAP;
                end
                S_IDLE_GAP: begin
                    if (cnt == CW'(BYTE_GAP - 1)) begin
                        cnt     <= '0;
                        bus_req <= 1'b1;
                        state   <= S_REQ;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_BOOT;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dual pad poller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f psx_dual_pad.f \
    --top-module tb_psx_dual_pad \
    -o sim_psx_dual_pad

# the simulator exits nonzero on a failed check, the log decides either way
./obj_dir/sim_psx_dual_pad > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_psx_dual_pad.sv ====
`default_nettype none

module tb_psx_dual_pad;
    import psx_pad_pkg::*;

    localparam int         TIMEOUT = 3000;   // cycles per wait
    localparam logic [3:0] NO_DROP = 4'hf;

    typedef struct packed {
        logic        port;
        logic        analog;
        logic [15:0] buttons;
        logic [7:0]  rx;
        logic [7:0]  ry;
        logic [7:0]  lx;
        logic [7:0]  ly;
        logic [3:0]  drop_ack;
        logic        exp_error;
    } row_t;

    logic                 clk;
    logic                 rst;
    logic                 data;
    logic                 ack;
    logic                 psx_clk;
    logic                 cmd;
    logic [1:0]           att;
    pad_report_u [1:0]    report;
    logic [1:0]           report_valid;
    logic [1:0]           poll_error;

    logic [1:0]           cfg_analog;
    logic [1:0][15:0]     cfg_buttons;
    logic [1:0][7:0]      cfg_rx;
    logic [1:0][7:0]      cfg_ry;
    logic [1:0][7:0]      cfg_lx;
    logic [1:0][7:0]      cfg_ly;
    logic [1:0][3:0]      cfg_drop;
    logic [1:0]           pad_data;
    logic [1:0]           pad_ack;
    logic [1:0][8:0][7:0] cmd_log;

    row_t        rows[$];
    pad_report_u last_good[2];
    logic [31:0] seed;

    assign data = pad_data[0] & pad_data[1];   // open collector
    assign ack  = pad_ack[0] & pad_ack[1];

    psx_dual_pad #(
        .HALF_BIT    (2),
        .ACK_TIMEOUT (20),
        .BYTE_GAP    (4),
        .BOOT_CYCLES (50)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .data         (data),
        .ack          (ack),
        .psx_clk      (psx_clk),
        .cmd          (cmd),
        .att          (att),
        .report       (report),
        .report_valid (report_valid),
        .poll_error   (poll_error)
    );

    for (genvar p = 0; p < 2; p++) begin : g_pad
        psx_pad_model u_pad (
            .clk      (clk),
            .rst      (rst),
            .att      (att[p]),
            .psx_clk  (psx_clk),
            .cmd      (cmd),
            .analog   (cfg_analog[p]),
            .buttons  (cfg_buttons[p]),
            .rx       (cfg_rx[p]),
            .ry       (cfg_ry[p]),
            .lx       (cfg_lx[p]),
            .ly       (cfg_ly[p]),
            .drop_ack (cfg_drop[p]),
            .data     (pad_data[p]),
            .ack      (pad_ack[p]),
            .cmd_log  (cmd_log[p])
        );
    end

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("The testbench gave up: %s did not happen within %0d cycles.", what, TIMEOUT);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic add_row(input logic port, input logic analog, input logic [3:0] drop);
        row_t r;
        r.port      = port;
        r.analog    = analog;
        seed        = lcg_next(seed);
        r.buttons   = seed[31:16];
        seed        = lcg_next(seed);
        r.rx        = seed[23:16];
        seed        = lcg_next(seed);
        r.ry        = seed[23:16];
        seed        = lcg_next(seed);
        r.lx        = seed[23:16];
        seed        = lcg_next(seed);
        r.ly        = seed[23:16];
        r.drop_ack  = drop;
        r.exp_error = (drop != NO_DROP);
        rows.push_back(r);
    endtask

    task automatic wait_att(input int port, input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (att[port] !== level) begin
            if (n >= TIMEOUT) begin
                report_timeout("an att edge");
            end else begin
                n++;
                @(posedge clk);
            end
        end
    endtask

    task automatic wait_result(input int port, output logic got_valid, output logic got_error);
        int n;
        n = 0;
        @(posedge clk);
        while (!report_valid[port] && !poll_error[port]) begin
            if (n >= TIMEOUT) begin
                report_timeout("the end of a poll");
            end else begin
                n++;
                @(posedge clk);
            end
        end
        got_valid = report_valid[port];
        got_error = poll_error[port];
    endtask

    task automatic check_report(input int port, input pad_report_u exp);
        check_eq(64'(report[port].fields.buttons), 64'(exp.fields.buttons), "buttons");
        check_eq(64'(report[port].fields.rx), 64'(exp.fields.rx), "rx");
        check_eq(64'(report[port].fields.ry), 64'(exp.fields.ry), "ry");
        check_eq(64'(report[port].fields.lx), 64'(exp.fields.lx), "lx");
        check_eq(64'(report[port].fields.ly), 64'(exp.fields.ly), "ly");
        check_eq(64'(report[port].fields.pad_id), 64'(exp.fields.pad_id), "pad_id");
    endtask

    // only one port may hold att low on the shared bus
    always @(posedge clk) begin
        if (!rst) check_eq(64'(att != 2'b00), 64'(1), "att high on some port");
    end

    initial begin
        row_t        r;
        pad_report_u exp;
        logic        got_valid;
        logic        got_error;
        logic [7:0]  exp_cmd;

        rst         <= 1'b1;
        cfg_analog  <= '0;
        cfg_buttons <= '1;
        cfg_rx      <= '0;
        cfg_ry      <= '0;
        cfg_lx      <= '0;
        cfg_ly      <= '0;
        cfg_drop    <= {NO_DROP, NO_DROP};
        seed = 32'd4850;
        add_row(1'b0, 1'b1, NO_DROP);
        add_row(1'b1, 1'b0, NO_DROP);
        add_row(1'b1, 1'b1, NO_DROP);
        add_row(1'b0, 1'b1, 4'd4);      // ack lost after the buttons high byte
        add_row(1'b0, 1'b1, NO_DROP);
        add_row(1'b1, 1'b0, 4'd2);
        add_row(1'b1, 1'b0, NO_DROP);
        add_row(1'b0, 1'b0, NO_DROP);
        for (int p = 0; p < 2; p++) begin
            last_good[p].fields.pad     = 8'h00;
            last_good[p].fields.buttons = 16'hffff;
            last_good[p].fields.rx      = 8'h80;
            last_good[p].fields.ry      = 8'h80;
            last_good[p].fields.lx      = 8'h80;
            last_good[p].fields.ly      = 8'h80;
            last_good[p].fields.pad_id  = 8'h00;
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_eq(64'(psx_clk), 64'(1), "psx_clk after reset");
        check_eq(64'(cmd), 64'(1), "cmd after reset");
        check_eq(64'(att), 64'(2'b11), "att after reset");
        check_eq(64'(report_valid), 64'(0), "report_valid after reset");
        check_eq(64'(poll_error), 64'(0), "poll_error after reset");
        check_report(0, last_good[0]);
        check_report(1, last_good[1]);

        foreach (rows[i]) begin
            r = rows[i];
            @(posedge clk);
            cfg_analog[r.port]  <= r.analog;
            cfg_buttons[r.port] <= r.buttons;
            cfg_rx[r.port]      <= r.rx;
            cfg_ry[r.port]      <= r.ry;
            cfg_lx[r.port]      <= r.lx;
            cfg_ly[r.port]      <= r.ly;
            cfg_drop[r.port]    <= r.drop_ack;
            // the model takes new values at att fall so a running poll is skipped
            wait_att(int'(r.port), 1'b1);
            wait_att(int'(r.port), 1'b0);
            wait_result(int'(r.port), got_valid, got_error);
            check_eq(64'(got_error), 64'(r.exp_error), "poll_error");
            check_eq(64'(got_valid), 64'(!r.exp_error), "report_valid");
            if (!r.exp_error) begin
                exp.fields.pad     = 8'h00;
                exp.fields.buttons = r.buttons;
                exp.fields.pad_id  = r.analog ? 8'h73 : 8'h41;
                exp.fields.rx      = r.analog ? r.rx : 8'h80;   // digital sticks centered
                exp.fields.ry      = r.analog ? r.ry : 8'h80;
                exp.fields.lx      = r.analog ? r.lx : 8'h80;
                exp.fields.ly      = r.analog ? r.ly : 8'h80;
                last_good[r.port]  = exp;
            end
            check_report(int'(r.port), last_good[r.port]);
            if (r.port == 1'b0 && r.analog && !r.exp_error) begin
                for (int k = 0; k < 9; k++) begin
                    exp_cmd = (k == 0) ? 8'h01 : (k == 1) ? 8'h42 : 8'h00;
                    check_eq(64'(cmd_log[0][k]), 64'(exp_cmd), "command byte at the pad");
                end
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
